// File: rtl/axis_fifo.sv
// Single-clock stream FIFO
`timescale 1ns/1ps

module axis_fifo import sdr_pkg::*; #(
    parameter type T  = eth_beat_t,
    parameter int  AW = ETH_FIFO_AW
) (
    input  logic bus_clk,
    input  logic global_rst,

    // Upstream side
    input  T     i_data,
    input  logic i_valid,
    output logic o_in_ready,

    // Downstream side
    output T     o_data,
    output logic o_valid,
    input  logic i_ready
);

    localparam int DEPTH = 2 ** AW;

    localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    ////////////////////
    // Flags
    ////////////////////
    assign o_in_ready = (count != FULL_CNT);
    assign o_valid    = (count != '0);

    assign wr_en = i_valid && o_in_ready;
    assign rd_en = o_valid && i_ready;

    // Head of queue
    assign o_data = mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge bus_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap on their own at the power of two depth
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    // Full and not drained means an offered beat was refused
    a_no_write_when_full : assert property (
        @(posedge bus_clk) disable iff (global_rst)
        (!o_in_ready && !rd_en) |=> !o_in_ready && (wr_ptr == $past(wr_ptr))
    ) else $error("FIFO accepted a beat while full");

    a_hold_under_stall : assert property (
        @(posedge bus_clk) disable iff (global_rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
    ) else $error("FIFO output changed under back-pressure");

endmodule

// File: rtl/clock_ready_timer.sv
// Clocks ready settling timer
`timescale 1ns/1ps

module clock_ready_timer import sdr_pkg::*; (
    input  logic bus_clk,
    input  logic global_rst,
    input  logic i_pll_locked,
    output logic o_clocks_ready
);

    localparam logic [SETTLE_CNT_W-1:0] LAST_CNT = SETTLE_CNT_W'(SETTLE_CYCLES - 1);

    logic [SETTLE_CNT_W-1:0] settle_cnt;

    // Count from the first locked edge, then hold ready
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            settle_cnt     <= '0;
            o_clocks_ready <= 1'b0;
        end else if (!i_pll_locked) begin
            // Lock lost so start over
            settle_cnt     <= '0;
            o_clocks_ready <= 1'b0;
        end else if (!o_clocks_ready) begin
            settle_cnt     <= settle_cnt + 1'b1;
            o_clocks_ready <= (settle_cnt == LAST_CNT);
        end
    end

    // Ready must drop right after any unlocked edge
    a_ready_needs_lock : assert property (
        @(posedge bus_clk) disable iff (global_rst)
        !$past(i_pll_locked) |-> !o_clocks_ready
    ) else $error("clocks ready high after lock was lost");

endmodule

// File: rtl/codec_ctrl.sv
// AD9364 codec control
`timescale 1ns/1ps

module codec_ctrl import sdr_pkg::*; (
    input  logic                 bus_clk,
    input  logic                 global_rst,

    // Misc output word from the host
    input  logic [MISC_W-1:0]    i_misc_outs,

    // Reference inputs
    input  logic                 i_ext_ref_is_pps,
    input  logic                 i_pps_in,
    input  logic                 i_clkin_10mhz,

    // Host SPI master
    input  logic [SPI_SEN_W-1:0] i_spi_sen,
    input  logic                 i_spi_sclk,
    input  logic                 i_spi_mosi,
    input  logic                 i_cat_spi_do,

    output logic                 o_cat_resetn,
    output logic                 o_clkin_10mhz_req,
    output logic                 o_ext_ref,
    output logic                 o_spi_miso,
    output logic                 o_cat_spi_en,
    output logic                 o_cat_spi_di,
    output logic                 o_cat_spi_clk
);

    logic [MISC_W-1:0] misc_outs_r;
    logic              ref_sel;
    logic              codec_rst;
    logic              codec_sel_n;

    ////////////////////
    // Misc register
    ////////////////////
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            misc_outs_r <= '0;
        end else begin
            misc_outs_r <= i_misc_outs;
        end
    end

    assign ref_sel   = misc_outs_r[MISC_REF_SEL_BIT];
    assign codec_rst = misc_outs_r[MISC_CODEC_RST_BIT];

    // Codec reset pin is active low
    assign o_cat_resetn      = ~codec_rst;
    assign o_clkin_10mhz_req = ref_sel;

    ////////////////////
    // Reference mux
    ////////////////////
    // PPS wins, then 10 MHz if selected
    assign o_ext_ref = i_ext_ref_is_pps ? i_pps_in :
                       ref_sel          ? i_clkin_10mhz : 1'b0;

    ////////////////////
    // SPI gating
    ////////////////////
    // Enable line is active low and only the codec hangs off bit 0
    assign codec_sel_n = i_spi_sen[0];

    assign o_cat_spi_en  = codec_sel_n;
    assign o_cat_spi_clk = ~codec_sel_n & i_spi_sclk;
    assign o_cat_spi_di  = ~codec_sel_n & i_spi_mosi;
    assign o_spi_miso    = i_cat_spi_do;

    // Deselected codec sees a quiet bus
    a_spi_quiet_when_idle : assert property (
        @(posedge bus_clk) disable iff (global_rst)
        i_spi_sen[0] |-> (!o_cat_spi_clk && !o_cat_spi_di)
    ) else $error("SPI clock or data active while codec deselected");

endmodule

// File: rtl/radio_frontend.sv
// Radio front end and sample packing
`timescale 1ns/1ps

module radio_frontend import sdr_pkg::*; (
    input  logic                 bus_clk,
    input  logic                 global_rst,
    input  logic                 i_clocks_ready,

    input  logic [FE_GPIO_W-1:0] i_fe_gpio,

    input  logic [SAMPLE_W-1:0]  i_rx_i,
    input  logic [SAMPLE_W-1:0]  i_rx_q,
    input  logic                 i_rx_stb,
    input  logic [IQ_W-1:0]      i_tx_word,

    output logic                 o_tx_pa_en,
    output logic                 o_fe_sel_rx_rx2,
    output logic                 o_fe_sel_trx_tx,
    output logic                 o_fe_sel_rx_trx,
    output logic                 o_fe_sel_trx_rx,
    output logic [IQ_W-1:0]      o_rx_word,
    output logic                 o_rx_stb,
    output logic [SAMPLE_W-1:0]  o_tx_i,
    output logic [SAMPLE_W-1:0]  o_tx_q
);

    logic [FE_GPIO_W-1:0] fe_gpio_r;
    logic [IQ_W-1:0]      rx_packed;

    // Front-end GPIO register
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            fe_gpio_r <= '0;
        end else begin
            fe_gpio_r <= i_fe_gpio;
        end
    end

    assign o_tx_pa_en      = fe_gpio_r[FE_PA_BIT];
    assign o_fe_sel_rx_rx2 = fe_gpio_r[FE_RX_RX2_BIT];
    assign o_fe_sel_trx_tx = fe_gpio_r[FE_TRX_TX_BIT];
    assign o_fe_sel_rx_trx = fe_gpio_r[FE_RX_TRX_BIT];
    assign o_fe_sel_trx_rx = fe_gpio_r[FE_TRX_RX_BIT];

    ////////////////////
    // RX packing
    ////////////////////
    // Pad nibbles stay zero
    always_comb begin
        rx_packed                      = '0;
        rx_packed[I_MSB -: SAMPLE_W]   = i_rx_i;
        rx_packed[Q_MSB -: SAMPLE_W]   = i_rx_q;
    end

    // Radio side held in reset until clocks settle
    always_ff @(posedge bus_clk or posedge global_rst) begin
        if (global_rst) begin
            o_rx_word <= '0;
            o_rx_stb  <= 1'b0;
        end else if (!i_clocks_ready) begin
            o_rx_word <= '0;
            o_rx_stb  <= 1'b0;
        end else begin
            o_rx_stb <= i_rx_stb;
            if (i_rx_stb) begin
                o_rx_word <= rx_packed;
            end
        end
    end

    // TX unpacking
    assign o_tx_i = i_tx_word[I_MSB -: SAMPLE_W];
    assign o_tx_q = i_tx_word[Q_MSB -: SAMPLE_W];

    a_rx_stb_pulse : assert property (
        @(posedge bus_clk) disable iff (global_rst)
        (o_rx_stb && $past(o_rx_stb)) |-> ($past(i_rx_stb) && $past(i_rx_stb, 2))
    ) else $error("RX strobe stretched without input strobes");

endmodule

// File: rtl/sdr_glue_top.sv
// SDR board glue top level
`timescale 1ns/1ps

module sdr_glue_top import sdr_pkg::*; (
    input  logic                               bus_clk,
    input  logic                               global_rst,

    // Lock and readiness
    input  logic                               i_pll_locked,
    output logic                               o_clocks_ready,

    // Misc word and reference
    input  logic [MISC_W-1:0]                  i_misc_outs,
    input  logic                               i_ext_ref_is_pps,
    input  logic                               i_pps_in,
    input  logic                               i_clkin_10mhz,
    output logic                               o_ext_ref,
    output logic                               o_clkin_10mhz_req,

    // Codec reset and SPI
    output logic                               o_cat_resetn,
    input  logic [SPI_SEN_W-1:0]               i_spi_sen,
    input  logic                               i_spi_sclk,
    input  logic                               i_spi_mosi,
    input  logic                               i_cat_spi_do,
    output logic                               o_spi_miso,
    output logic                               o_cat_spi_en,
    output logic                               o_cat_spi_di,
    output logic                               o_cat_spi_clk,

    // Constant codec pins
    output logic [$bits(CODEC_CTL_IN_VAL)-1:0] o_cat_ctl_in,
    output logic                               o_cat_en,
    output logic                               o_cat_en_agc,
    output logic                               o_cat_txnrx,

    // Front end
    input  logic [FE_GPIO_W-1:0]               i_fe_gpio,
    output logic                               o_tx_pa_en,
    output logic                               o_fe_sel_rx_rx2,
    output logic                               o_fe_sel_trx_tx,
    output logic                               o_fe_sel_rx_trx,
    output logic                               o_fe_sel_trx_rx,

    // Samples
    input  logic [SAMPLE_W-1:0]                i_rx_i,
    input  logic [SAMPLE_W-1:0]                i_rx_q,
    input  logic                               i_rx_stb,
    output logic [IQ_W-1:0]                    o_rx_word,
    output logic                               o_rx_stb,
    input  logic [IQ_W-1:0]                    i_tx_word,
    output logic [SAMPLE_W-1:0]                o_tx_i,
    output logic [SAMPLE_W-1:0]                o_tx_q,

    // Ethernet TX, ARM to PHY
    input  logic [ETH_DATA_W-1:0]              i_eth_tx_tdata,
    input  logic [ETH_KEEP_W-1:0]              i_eth_tx_tkeep,
    input  logic                               i_eth_tx_tlast,
    input  logic                               i_eth_tx_tvalid,
    output logic                               o_eth_tx_tready,
    output logic [ETH_DATA_W-1:0]              o_phy_tx_tdata,
    output logic [ETH_KEEP_W-1:0]              o_phy_tx_tkeep,
    output logic                               o_phy_tx_tlast,
    output logic                               o_phy_tx_tvalid,
    input  logic                               i_phy_tx_tready,

    // Ethernet RX, PHY to ARM
    input  logic [ETH_DATA_W-1:0]              i_phy_rx_tdata,
    input  logic [ETH_KEEP_W-1:0]              i_phy_rx_tkeep,
    input  logic                               i_phy_rx_tlast,
    input  logic                               i_phy_rx_tvalid,
    output logic                               o_phy_rx_tready,
    output logic [ETH_DATA_W-1:0]              o_eth_rx_tdata,
    output logic [ETH_KEEP_W-1:0]              o_eth_rx_tkeep,
    output logic                               o_eth_rx_tlast,
    output logic                               o_eth_rx_tvalid,
    input  logic                               i_eth_rx_tready
);

    logic      clocks_ready;
    eth_beat_t tx_in_beat;
    eth_beat_t tx_out_beat;
    eth_beat_t rx_in_beat;
    eth_beat_t rx_out_beat;

    clock_ready_timer u_clock_ready_timer (
        .bus_clk        (bus_clk),
        .global_rst     (global_rst),
        .i_pll_locked   (i_pll_locked),
        .o_clocks_ready (clocks_ready)
    );

    assign o_clocks_ready = clocks_ready;

    codec_ctrl u_codec_ctrl (
        .bus_clk           (bus_clk),
        .global_rst        (global_rst),
        .i_misc_outs       (i_misc_outs),
        .i_ext_ref_is_pps  (i_ext_ref_is_pps),
        .i_pps_in          (i_pps_in),
        .i_clkin_10mhz     (i_clkin_10mhz),
        .i_spi_sen         (i_spi_sen),
        .i_spi_sclk        (i_spi_sclk),
        .i_spi_mosi        (i_spi_mosi),
        .i_cat_spi_do      (i_cat_spi_do),
        .o_cat_resetn      (o_cat_resetn),
        .o_clkin_10mhz_req (o_clkin_10mhz_req),
        .o_ext_ref         (o_ext_ref),
        .o_spi_miso        (o_spi_miso),
        .o_cat_spi_en      (o_cat_spi_en),
        .o_cat_spi_di      (o_cat_spi_di),
        .o_cat_spi_clk     (o_cat_spi_clk)
    );

    // Codec runs in FDD with AGC enabled
    assign o_cat_ctl_in = CODEC_CTL_IN_VAL;
    assign o_cat_en     = 1'b1;
    assign o_cat_en_agc = 1'b1;
    assign o_cat_txnrx  = 1'b1;

    radio_frontend u_radio_frontend (
        .bus_clk         (bus_clk),
        .global_rst      (global_rst),
        .i_clocks_ready  (clocks_ready),
        .i_fe_gpio       (i_fe_gpio),
        .i_rx_i          (i_rx_i),
        .i_rx_q          (i_rx_q),
        .i_rx_stb        (i_rx_stb),
        .i_tx_word       (i_tx_word),
        .o_tx_pa_en      (o_tx_pa_en),
        .o_fe_sel_rx_rx2 (o_fe_sel_rx_rx2),
        .o_fe_sel_trx_tx (o_fe_sel_trx_tx),
        .o_fe_sel_rx_trx (o_fe_sel_rx_trx),
        .o_fe_sel_trx_rx (o_fe_sel_trx_rx),
        .o_rx_word       (o_rx_word),
        .o_rx_stb        (o_rx_stb),
        .o_tx_i          (o_tx_i),
        .o_tx_q          (o_tx_q)
    );

    ////////////////////
    // Ethernet FIFOs
    ////////////////////
    assign tx_in_beat = {i_eth_tx_tlast, i_eth_tx_tkeep, i_eth_tx_tdata};
    assign rx_in_beat = {i_phy_rx_tlast, i_phy_rx_tkeep, i_phy_rx_tdata};

    axis_fifo #(.T(eth_beat_t), .AW(ETH_FIFO_AW)) eth_tx_fifo (
        .bus_clk    (bus_clk),
        .global_rst (global_rst),
        .i_data     (tx_in_beat),
        .i_valid    (i_eth_tx_tvalid),
        .o_in_ready (o_eth_tx_tready),
        .o_data     (tx_out_beat),
        .o_valid    (o_phy_tx_tvalid),
        .i_ready    (i_phy_tx_tready)
    );

    axis_fifo #(.T(eth_beat_t), .AW(ETH_FIFO_AW)) eth_rx_fifo (
        .bus_clk    (bus_clk),
        .global_rst (global_rst),
        .i_data     (rx_in_beat),
        .i_valid    (i_phy_rx_tvalid),
        .o_in_ready (o_phy_rx_tready),
        .o_data     (rx_out_beat),
        .o_valid    (o_eth_rx_tvalid),
        .i_ready    (i_eth_rx_tready)
    );

    assign o_phy_tx_tdata = tx_out_beat.tdata;
    assign o_phy_tx_tkeep = tx_out_beat.tkeep;
    assign o_phy_tx_tlast = tx_out_beat.tlast;

    assign o_eth_rx_tdata = rx_out_beat.tdata;
    assign o_eth_rx_tkeep = rx_out_beat.tkeep;
    assign o_eth_rx_tlast = rx_out_beat.tlast;

endmodule

// File: rtl/sdr_pkg.sv
// SDR glue shared definitions
package sdr_pkg;

    ////////////////////
    // Radio samples
    ////////////////////
    localparam int SAMPLE_W = 12;
    localparam int IQ_W     = 32;
    localparam int I_MSB    = 31;
    localparam int Q_MSB    = 15;

    // Front-end GPIO word and its decoded bits
    localparam int FE_GPIO_W     = 8;
    localparam int FE_PA_BIT     = 7;
    localparam int FE_RX_RX2_BIT = 6;
    localparam int FE_TRX_TX_BIT = 5;
    localparam int FE_RX_TRX_BIT = 4;
    localparam int FE_TRX_RX_BIT = 3;

    ////////////////////
    // Codec control
    ////////////////////
    localparam int MISC_W             = 32;
    localparam int MISC_REF_SEL_BIT   = 0;
    localparam int MISC_CODEC_RST_BIT = 2;
    localparam int SPI_SEN_W          = 8;

    // Driven on the four codec control inputs
    localparam logic [3:0] CODEC_CTL_IN_VAL = 4'd1;

    // Settling time after clock lock
    localparam int SETTLE_CYCLES = 64;
    localparam int SETTLE_CNT_W  = 7;

    ////////////////////
    // Ethernet streams
    ////////////////////
    localparam int ETH_DATA_W  = 64;
    localparam int ETH_KEEP_W  = 8;
    localparam int ETH_FIFO_AW = 5;

    // One stream beat as stored in the FIFOs
    typedef struct packed {
        logic                  tlast;
        logic [ETH_KEEP_W-1:0] tkeep;
        logic [ETH_DATA_W-1:0] tdata;
    } eth_beat_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Build and run the SDR glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f src.f --top-module tb_sdr_glue -o tb_sdr_glue \
    && ./obj_dir/tb_sdr_glue | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

// File: src.f
rtl/sdr_pkg.sv
rtl/clock_ready_timer.sv
rtl/codec_ctrl.sv
rtl/radio_frontend.sv
rtl/axis_fifo.sv
rtl/sdr_glue_top.sv
testbench/tb_sdr_glue.sv

// File: testbench/tb_sdr_glue.sv
// SDR glue directed testbench
`timescale 1ns/1ps

module tb_sdr_glue import sdr_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic                  bus_clk;
    logic                  global_rst;
    logic                  i_pll_locked;
    logic                  o_clocks_ready;
    logic [MISC_W-1:0]     i_misc_outs;
    logic                  i_ext_ref_is_pps;
    logic                  i_pps_in;
    logic                  i_clkin_10mhz;
    logic                  o_ext_ref;
    logic                  o_clkin_10mhz_req;
    logic                  o_cat_resetn;
    logic [SPI_SEN_W-1:0]  i_spi_sen;
    logic                  i_spi_sclk;
    logic                  i_spi_mosi;
    logic                  i_cat_spi_do;
    logic                  o_spi_miso;
    logic                  o_cat_spi_en;
    logic                  o_cat_spi_di;
    logic                  o_cat_spi_clk;
    logic [3:0]            o_cat_ctl_in;
    logic                  o_cat_en;
    logic                  o_cat_en_agc;
    logic                  o_cat_txnrx;
    logic [FE_GPIO_W-1:0]  i_fe_gpio;
    logic                  o_tx_pa_en;
    logic                  o_fe_sel_rx_rx2;
    logic                  o_fe_sel_trx_tx;
    logic                  o_fe_sel_rx_trx;
    logic                  o_fe_sel_trx_rx;
    logic [SAMPLE_W-1:0]   i_rx_i;
    logic [SAMPLE_W-1:0]   i_rx_q;
    logic                  i_rx_stb;
    logic [IQ_W-1:0]       o_rx_word;
    logic                  o_rx_stb;
    logic [IQ_W-1:0]       i_tx_word;
    logic [SAMPLE_W-1:0]   o_tx_i;
    logic [SAMPLE_W-1:0]   o_tx_q;
    logic [ETH_DATA_W-1:0] i_eth_tx_tdata;
    logic [ETH_KEEP_W-1:0] i_eth_tx_tkeep;
    logic                  i_eth_tx_tlast;
    logic                  i_eth_tx_tvalid;
    logic                  o_eth_tx_tready;
    logic [ETH_DATA_W-1:0] o_phy_tx_tdata;
    logic [ETH_KEEP_W-1:0] o_phy_tx_tkeep;
    logic                  o_phy_tx_tlast;
    logic                  o_phy_tx_tvalid;
    logic                  i_phy_tx_tready;
    logic [ETH_DATA_W-1:0] i_phy_rx_tdata;
    logic [ETH_KEEP_W-1:0] i_phy_rx_tkeep;
    logic                  i_phy_rx_tlast;
    logic                  i_phy_rx_tvalid;
    logic                  o_phy_rx_tready;
    logic [ETH_DATA_W-1:0] o_eth_rx_tdata;
    logic [ETH_KEEP_W-1:0] o_eth_rx_tkeep;
    logic                  o_eth_rx_tlast;
    logic                  o_eth_rx_tvalid;
    logic                  i_eth_rx_tready;

    integer seed;
    int     check_count;
    int     mismatch_count;
    int     failure_count;
    int     cycle_count;

    sdr_glue_top DUT (.*);

    initial begin
        bus_clk = 1'b0;
        forever #10 bus_clk = ~bus_clk;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge bus_clk);
        #1;
    endtask

    function automatic eth_beat_t random_beat(input logic last);
        eth_beat_t   beat;
        logic [31:0] rnd;
        rnd        = next_random();
        beat.tdata = {next_random(), rnd};
        beat.tkeep = rnd[31:24];
        beat.tlast = last;
        return beat;
    endfunction

    // Path 0 is the TX stream, path 1 the RX stream
    task automatic drive_upstream(input bit path, input logic valid, input eth_beat_t beat);
        if (path == 1'b0) begin
            i_eth_tx_tvalid = valid;
            {i_eth_tx_tlast, i_eth_tx_tkeep, i_eth_tx_tdata} = beat;
        end else begin
            i_phy_rx_tvalid = valid;
            {i_phy_rx_tlast, i_phy_rx_tkeep, i_phy_rx_tdata} = beat;
        end
    endtask

    task automatic drive_downstream_ready(input bit path, input logic ready);
        if (path == 1'b0) begin
            i_phy_tx_tready = ready;
        end else begin
            i_eth_rx_tready = ready;
        end
    endtask

    function automatic logic upstream_ready(input bit path);
        return path ? o_phy_rx_tready : o_eth_tx_tready;
    endfunction

    function automatic logic downstream_valid(input bit path);
        return path ? o_eth_rx_tvalid : o_phy_tx_tvalid;
    endfunction

    function automatic eth_beat_t downstream_beat(input bit path);
        return path ? {o_eth_rx_tlast, o_eth_rx_tkeep, o_eth_rx_tdata}
                    : {o_phy_tx_tlast, o_phy_tx_tkeep, o_phy_tx_tdata};
    endfunction

    task automatic check_beat(input bit path, input eth_beat_t got, input eth_beat_t exp);
        check_value(path ? "o_eth_rx_tdata" : "o_phy_tx_tdata", got.tdata, exp.tdata);
        check_value(path ? "o_eth_rx_tkeep" : "o_phy_tx_tkeep", got.tkeep, exp.tkeep);
        check_value(path ? "o_eth_rx_tlast" : "o_phy_tx_tlast", got.tlast, exp.tlast);
    endtask

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, failure_count);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    // Strobes must not get through before clocks settle
    task automatic test_rx_held_in_reset();
        logic [31:0] rnd;
        rnd      = next_random();
        i_rx_i   = rnd[11:0];
        i_rx_q   = rnd[23:12];
        i_rx_stb = 1'b1;
        next_cycle();
        i_rx_stb = 1'b0;
        check_value("o_rx_stb", o_rx_stb, 1'b0);
        check_value("o_rx_word", o_rx_word, '0);
        next_cycle();
        check_value("o_rx_stb", o_rx_stb, 1'b0);
    endtask

    task automatic test_clocks_ready();
        check_value("o_clocks_ready", o_clocks_ready, 1'b0);
        i_pll_locked = 1'b1;
        for (int k = 1; k <= SETTLE_CYCLES; k++) begin
            next_cycle();
            check_value("o_clocks_ready", o_clocks_ready, (k == SETTLE_CYCLES));
        end
        repeat (3) begin
            next_cycle();
            check_value("o_clocks_ready", o_clocks_ready, 1'b1);
        end
        i_pll_locked = 1'b0;
        next_cycle();
        check_value("o_clocks_ready", o_clocks_ready, 1'b0);
        // Relock for the tests that follow
        i_pll_locked = 1'b1;
        repeat (SETTLE_CYCLES) begin
            next_cycle();
        end
        check_value("o_clocks_ready", o_clocks_ready, 1'b1);
    endtask

    task automatic test_codec_ctrl();
        logic [31:0] words [5];
        logic [31:0] prev;
        logic [2:0]  combo;
        logic        exp_ref;
        words[0] = 32'h0000_0004;
        words[1] = 32'h0000_0001;
        words[2] = 32'h0000_0005;
        words[3] = next_random();
        words[4] = 32'h0;
        prev     = '0;
        for (int n = 0; n < 5; n++) begin
            i_misc_outs = words[n];
            #1;
            // Old value still visible before the edge
            check_value("o_cat_resetn", o_cat_resetn, !prev[2]);
            check_value("o_clkin_10mhz_req", o_clkin_10mhz_req, prev[0]);
            next_cycle();
            check_value("o_cat_resetn", o_cat_resetn, !words[n][2]);
            check_value("o_clkin_10mhz_req", o_clkin_10mhz_req, words[n][0]);
            prev = words[n];
        end
        for (int sel = 0; sel < 2; sel++) begin
            i_misc_outs = {31'b0, sel[0]};
            next_cycle();
            for (int c = 0; c < 8; c++) begin
                combo = c[2:0];
                {i_ext_ref_is_pps, i_pps_in, i_clkin_10mhz} = combo;
                #1;
                exp_ref = combo[2] ? combo[1] : (sel[0] ? combo[0] : 1'b0);
                check_value("o_ext_ref", o_ext_ref, exp_ref);
            end
            next_cycle();
        end
        i_misc_outs = '0;
        check_value("o_cat_ctl_in", o_cat_ctl_in, 4'd1);
        check_value("o_cat_en", o_cat_en, 1'b1);
        check_value("o_cat_en_agc", o_cat_en_agc, 1'b1);
        check_value("o_cat_txnrx", o_cat_txnrx, 1'b1);
        next_cycle();
    endtask

    task automatic test_spi_gating();
        logic [31:0] rnd;
        logic        desel;
        for (int n = 0; n < 12; n++) begin
            rnd          = next_random();
            desel        = n[0];
            i_spi_sen    = {rnd[7:1], desel};
            i_spi_sclk   = rnd[8];
            i_spi_mosi   = rnd[9];
            i_cat_spi_do = rnd[10];
            #1;
            check_value("o_cat_spi_en", o_cat_spi_en, desel);
            check_value("o_cat_spi_clk", o_cat_spi_clk, desel ? 1'b0 : rnd[8]);
            check_value("o_cat_spi_di", o_cat_spi_di, desel ? 1'b0 : rnd[9]);
            check_value("o_spi_miso", o_spi_miso, rnd[10]);
            next_cycle();
        end
        i_spi_sen = '1;
    endtask

    task automatic test_radio_frontend();
        logic [31:0]         rnd;
        logic [SAMPLE_W-1:0] s_i;
        logic [SAMPLE_W-1:0] s_q;
        repeat (8) begin
            rnd       = next_random();
            i_fe_gpio = rnd[7:0];
            next_cycle();
            check_value("o_tx_pa_en", o_tx_pa_en, rnd[7]);
            check_value("o_fe_sel_rx_rx2", o_fe_sel_rx_rx2, rnd[6]);
            check_value("o_fe_sel_trx_tx", o_fe_sel_trx_tx, rnd[5]);
            check_value("o_fe_sel_rx_trx", o_fe_sel_rx_trx, rnd[4]);
            check_value("o_fe_sel_trx_rx", o_fe_sel_trx_rx, rnd[3]);
        end
        repeat (6) begin
            rnd      = next_random();
            s_i      = rnd[11:0];
            s_q      = rnd[23:12];
            i_rx_i   = s_i;
            i_rx_q   = s_q;
            i_rx_stb = 1'b1;
            next_cycle();
            i_rx_stb = 1'b0;
            check_value("o_rx_stb", o_rx_stb, 1'b1);
            check_value("o_rx_word", o_rx_word, {s_i, 4'h0, s_q, 4'h0});
            next_cycle();
            check_value("o_rx_stb", o_rx_stb, 1'b0);
            check_value("o_rx_word", o_rx_word, {s_i, 4'h0, s_q, 4'h0});
        end
        repeat (6) begin
            rnd       = next_random();
            i_tx_word = rnd;
            #1;
            check_value("o_tx_i", o_tx_i, rnd[31:20]);
            check_value("o_tx_q", o_tx_q, rnd[15:4]);
            next_cycle();
        end
    endtask

    // Random frames in, random back-pressure out, scoreboard in between
    task automatic stream_check(input bit path, input int frames);
        eth_beat_t   to_send [$];
        eth_beat_t   expected [$];
        int          total;
        int          received;
        int          len;
        logic        accepted;
        logic [31:0] rnd;
        for (int f = 0; f < frames; f++) begin
            rnd = next_random();
            len = int'(rnd[2:0]) + 1;
            for (int b = 0; b < len; b++) begin
                to_send.push_back(random_beat(b == len - 1));
            end
        end
        total    = to_send.size();
        received = 0;
        fork
            begin
                while (to_send.size() > 0) begin
                    drive_upstream(path, 1'b1, to_send[0]);
                    #1;
                    accepted = upstream_ready(path);
                    next_cycle();
                    if (accepted) begin
                        expected.push_back(to_send.pop_front());
                    end
                end
                drive_upstream(path, 1'b0, '0);
            end
            begin
                while (received < total) begin
                    rnd = next_random();
                    drive_downstream_ready(path, rnd[0]);
                    #1;
                    if (downstream_valid(path) && rnd[0]) begin
                        if (expected.size() == 0) begin
                            report_failure("FIFO delivered a beat that was never accepted");
                        end else begin
                            check_beat(path, downstream_beat(path), expected.pop_front());
                        end
                        received++;
                    end
                    next_cycle();
                end
                drive_downstream_ready(path, 1'b0);
            end
        join
        check_value("undelivered beats", expected.size(), 0);
        check_value(path ? "o_eth_rx_tvalid" : "o_phy_tx_tvalid", downstream_valid(path), 1'b0);
    endtask

    // Stalled output, ready must drop after exactly the FIFO depth
    task automatic fill_check();
        eth_beat_t expected [$];
        eth_beat_t beat;
        int        accepted_cnt;
        int        tries;
        logic      ready_seen;
        drive_downstream_ready(1'b0, 1'b0);
        accepted_cnt = 0;
        tries        = 0;
        ready_seen   = 1'b1;
        while (ready_seen && tries < 40) begin
            beat = random_beat(1'b0);
            drive_upstream(1'b0, 1'b1, beat);
            #1;
            ready_seen = o_eth_tx_tready;
            next_cycle();
            if (ready_seen) begin
                expected.push_back(beat);
                accepted_cnt++;
            end
            tries++;
        end
        check_value("accepted beats", accepted_cnt, 32);
        drive_upstream(1'b0, 1'b0, '0);
        drive_downstream_ready(1'b0, 1'b1);
        while (expected.size() > 0) begin
            #1;
            check_value("o_phy_tx_tvalid", o_phy_tx_tvalid, 1'b1);
            check_beat(1'b0, downstream_beat(1'b0), expected.pop_front());
            next_cycle();
        end
        drive_downstream_ready(1'b0, 1'b0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        seed             = 32'he74;
        check_count      = 0;
        mismatch_count   = 0;
        failure_count    = 0;
        global_rst       = 1'b1;
        i_pll_locked     = 1'b0;
        i_misc_outs      = '0;
        i_ext_ref_is_pps = 1'b0;
        i_pps_in         = 1'b0;
        i_clkin_10mhz    = 1'b0;
        i_spi_sen        = '1;
        i_spi_sclk       = 1'b0;
        i_spi_mosi       = 1'b0;
        i_cat_spi_do     = 1'b0;
        i_fe_gpio        = '0;
        i_rx_i           = '0;
        i_rx_q           = '0;
        i_rx_stb         = 1'b0;
        i_tx_word        = '0;
        drive_upstream(1'b0, 1'b0, '0);
        drive_upstream(1'b1, 1'b0, '0);
        i_phy_tx_tready  = 1'b0;
        i_eth_rx_tready  = 1'b0;
        repeat (5) begin
            @(posedge bus_clk);
        end
        #1;
        global_rst = 1'b0;
        test_rx_held_in_reset();
        test_clocks_ready();
        test_codec_ctrl();
        test_spi_gating();
        test_radio_frontend();
        stream_check(1'b0, 6);
        fill_check();
        stream_check(1'b1, 6);
        report_counts();
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge bus_clk);
            cycle_count++;
        end
        report_failure("run did not finish within the cycle limit");
        report_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
